// File: all.f
logic/test_frame_pkg.sv
logic/frame_timing_gen.sv
logic/test_pattern_gen.sv
logic/crc16_word.sv
logic/frame_crc_wrapper.sv
logic/test_frame_source.sv
tb/tb_clock_gen.sv
tb/test_frame_source_assertions.sv
tb/tb_test_frame_source.sv

// File: logic/crc16_word.sv
// crc-16/ccitt over 32-bit words, bit 31 first; held at CRC_INIT while fval is low
`timescale 1ns/1ps

module crc16_word import test_frame_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              fval,
	input  logic              crc_en,
	input  logic [DATA_W-1:0] data,
	output logic [CRC_W-1:0]  crc
);

	logic [CRC_W-1:0] crc_q;
	logic [CRC_W-1:0] crc_next;
	logic             fb;

	// ----------------------------------------------------------------------
	// serial fold of one word, unrolled
	// ----------------------------------------------------------------------
	always_comb begin
		crc_next = crc_q;
		fb       = 1'b0;
		// msb of the word goes in first
		for (int i = DATA_W - 1; i >= 0; i--) begin
			fb       = crc_next[CRC_W-1] ^ data[i];
			crc_next = {crc_next[CRC_W-2:0], 1'b0};
			if (fb) begin
				crc_next = crc_next ^ CRC_POLY;
			end
		end
	end

	// ----------------------------------------------------------------------
	// running crc register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			crc_q <= CRC_INIT;
		end else if (!fval) begin
			// preset between frames
			crc_q <= CRC_INIT;
		end else if (crc_en) begin
			crc_q <= crc_next;
		end
	end

	// valid one cycle after the enabled beat
	assign crc = crc_q;

endmodule

// File: logic/frame_crc_wrapper.sv
// frame_size of zero not supported; trailer is the crc placed in both halves of dout
`timescale 1ns/1ps

module frame_crc_wrapper import test_frame_pkg::*; (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    fval,
	input  logic                    dval,
	input  logic [FRAME_SIZE_W-1:0] frame_size,
	input  logic [DATA_W-1:0]       pattern_data,
	input  logic [CRC_W-1:0]        crc,
	output logic                    crc_en,
	output logic [DATA_W-1:0]       dout,
	output logic                    dout_valid,
	output logic                    dout_fval,
	output logic                    dout_crc_beat
);

	logic [FRAME_SIZE_W-1:0] beat_cnt;
	logic                    crc_switch;

	// ----------------------------------------------------------------------
	// payload beat counter
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			beat_cnt <= '0;
		end else if (!fval) begin
			beat_cnt <= '0;
		end else if (dval) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// count reaching frame_size means trailer beat
	assign crc_switch = (beat_cnt == frame_size);
	// crc only sees payload words
	assign crc_en     = dval && (beat_cnt < frame_size);

	// ----------------------------------------------------------------------
	// output register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dout_valid    <= 1'b0;
			dout_fval     <= 1'b0;
			dout_crc_beat <= 1'b0;
		end else begin
			dout_valid    <= dval;
			dout_fval     <= fval;
			dout_crc_beat <= dval && crc_switch;
		end
	end

	// data word, no reset
	always_ff @(posedge clk) begin
		if (crc_switch) begin
			dout <= {crc, crc};
		end else begin
			dout <= pattern_data;
		end
	end

endmodule

// File: logic/frame_timing_gen.sv
// one frame of frame_size+1 beats per start; start ignored while busy; BLANK_CYCLES must be >= 1
`timescale 1ns/1ps

module frame_timing_gen import test_frame_pkg::*; #(
	parameter int BLANK_CYCLES = 4
) (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    start,
	input  logic [FRAME_SIZE_W-1:0] frame_size,
	output logic                    fval,
	output logic                    dval,
	output logic                    sof,
	output logic                    busy
);

	localparam int BLANK_W = (BLANK_CYCLES > 1) ? $clog2(BLANK_CYCLES) : 1;
	localparam logic [BLANK_W-1:0] BLANK_LAST = BLANK_W'(BLANK_CYCLES - 1);

	// fsm encoding
	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_ACTIVE = 2'd1;
	localparam logic [1:0] ST_BLANK  = 2'd2;

	logic [1:0]              state;
	logic [FRAME_SIZE_W-1:0] beat_cnt;
	logic [BLANK_W-1:0]      blank_cnt;

	// ----------------------------------------------------------------------
	// state machine
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			beat_cnt  <= '0;
			blank_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					// start only honoured here
					if (start) begin
						state    <= ST_ACTIVE;
						beat_cnt <= '0;
					end
				end
				ST_ACTIVE: begin
					// beats 0 .. frame_size, the last one is the trailer
					if (beat_cnt == frame_size) begin
						state     <= ST_BLANK;
						blank_cnt <= '0;
					end else begin
						beat_cnt <= beat_cnt + 1'b1;
					end
				end
				ST_BLANK: begin
					if (blank_cnt == BLANK_LAST) begin
						state <= ST_IDLE;
					end else begin
						blank_cnt <= blank_cnt + 1'b1;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// outputs straight from registered state
	assign fval = (state == ST_ACTIVE);
	// no gaps inside a frame
	assign dval = fval;
	assign sof  = fval && (beat_cnt == '0);
	assign busy = (state != ST_IDLE);

endmodule

// File: logic/test_frame_pkg.sv
// shared widths and constants; frame_size counts are limited to FRAME_SIZE_W bits
package test_frame_pkg;

	// ----------------------------------------------------------------------
	// widths
	// ----------------------------------------------------------------------
	localparam int FRAME_SIZE_W = 23;
	localparam int DATA_W       = 32;
	localparam int CRC_W        = 16;

	// payload pattern select
	typedef enum logic [1:0] {
		PAT_INCR      = 2'd0,
		PAT_FRAME_TAG = 2'd1,
		PAT_LFSR      = 2'd2,
		PAT_CHECKER   = 2'd3
	} pattern_t;

	// ----------------------------------------------------------------------
	// crc-16/ccitt, msb first, no reflection, no final xor
	// ----------------------------------------------------------------------
	localparam logic [CRC_W-1:0] CRC_POLY = 16'h1021;
	localparam logic [CRC_W-1:0] CRC_INIT = 16'hFFFF;

	// ----------------------------------------------------------------------
	// fibonacci lfsr for the pseudo random pattern
	// ----------------------------------------------------------------------
	// reloaded on every frame start
	localparam logic [DATA_W-1:0] LFSR_SEED = 32'h1357_9BDF;
	// taps 32, 22, 2, 1 mapped to bits 31, 21, 1, 0
	localparam logic [DATA_W-1:0] LFSR_TAPS = 32'h8020_0003;

endpackage

// File: logic/test_frame_source.sv
// test frame source; start pulse taken only when busy is low, frame_size >= 1 and stable per frame
`timescale 1ns/1ps

module test_frame_source import test_frame_pkg::*; #(
	parameter int BLANK_CYCLES = 4
) (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    start,
	input  logic [FRAME_SIZE_W-1:0] frame_size,
	input  pattern_t                pattern_sel,
	output logic [DATA_W-1:0]       dout,
	output logic                    dout_valid,
	output logic                    dout_fval,
	output logic                    dout_crc_beat,
	output logic                    busy
);

	logic              fval;
	logic              dval;
	logic              sof;
	logic              crc_en;
	logic [DATA_W-1:0] pattern_data;
	logic [CRC_W-1:0]  crc;

	// ----------------------------------------------------------------------
	// frame timing
	// ----------------------------------------------------------------------
	frame_timing_gen #(
		.BLANK_CYCLES (BLANK_CYCLES)
	) u_timing (
		.clk        (clk),
		.arst_n     (arst_n),
		.start      (start),
		.frame_size (frame_size),
		.fval       (fval),
		.dval       (dval),
		.sof        (sof),
		.busy       (busy)
	);

	// payload words
	test_pattern_gen u_pattern (
		.clk          (clk),
		.arst_n       (arst_n),
		.sof          (sof),
		.dval         (dval),
		.pattern_sel  (pattern_sel),
		.pattern_data (pattern_data)
	);

	// ----------------------------------------------------------------------
	// crc and trailer insertion
	// ----------------------------------------------------------------------
	crc16_word u_crc (
		.clk    (clk),
		.arst_n (arst_n),
		.fval   (fval),
		.crc_en (crc_en),
		.data   (pattern_data),
		.crc    (crc)
	);

	frame_crc_wrapper u_wrap (
		.clk           (clk),
		.arst_n        (arst_n),
		.fval          (fval),
		.dval          (dval),
		.frame_size    (frame_size),
		.pattern_data  (pattern_data),
		.crc           (crc),
		.crc_en        (crc_en),
		.dout          (dout),
		.dout_valid    (dout_valid),
		.dout_fval     (dout_fval),
		.dout_crc_beat (dout_crc_beat)
	);

endmodule

// File: logic/test_pattern_gen.sv
// pattern word is combinational per dval beat; pattern_sel only taken at sof
`timescale 1ns/1ps

module test_pattern_gen import test_frame_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              sof,
	input  logic              dval,
	input  pattern_t          pattern_sel,
	output logic [DATA_W-1:0] pattern_data
);

	pattern_t                pat_q;
	logic [FRAME_SIZE_W-1:0] idx_q;
	logic [7:0]              frame_cnt;
	logic [DATA_W-1:0]       lfsr_q;
	logic                    phase_q;
	logic                    dval_q;

	// values in effect for the current beat
	pattern_t                cur_pat;
	logic [FRAME_SIZE_W-1:0] cur_idx;
	logic [DATA_W-1:0]       cur_lfsr;
	logic                    cur_phase;
	logic [23:0]             idx_lo;
	logic                    lfsr_fb;

	// ----------------------------------------------------------------------
	// beat state, restarted on sof
	// ----------------------------------------------------------------------
	// sof beat sees fresh values before the registers catch up
	assign cur_pat   = sof ? pattern_sel : pat_q;
	assign cur_idx   = sof ? '0 : idx_q;
	assign cur_lfsr  = sof ? LFSR_SEED : lfsr_q;
	assign cur_phase = sof ? 1'b0 : phase_q;

	assign idx_lo  = 24'(cur_idx);
	// fibonacci feedback
	assign lfsr_fb = ^(cur_lfsr & LFSR_TAPS);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pat_q   <= PAT_INCR;
			idx_q   <= '0;
			lfsr_q  <= LFSR_SEED;
			phase_q <= 1'b0;
		end else if (dval) begin
			pat_q   <= cur_pat;
			idx_q   <= cur_idx + 1'b1;
			lfsr_q  <= {cur_lfsr[DATA_W-2:0], lfsr_fb};
			phase_q <= ~cur_phase;
		end
	end

	// ----------------------------------------------------------------------
	// frame number for the tag pattern
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dval_q    <= 1'b0;
			frame_cnt <= '0;
		end else begin
			dval_q <= dval;
			// falling dval marks end of frame
			if (dval_q && !dval) begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// word select
	// ----------------------------------------------------------------------
	always_comb begin
		case (cur_pat)
			PAT_INCR:      pattern_data = DATA_W'(cur_idx);
			PAT_FRAME_TAG: pattern_data = {frame_cnt, idx_lo};
			PAT_LFSR:      pattern_data = cur_lfsr;
			PAT_CHECKER:   pattern_data = cur_phase ? 32'hAAAA_AAAA : 32'h5555_5555;
			default:       pattern_data = '0;
		endcase
	end

endmodule

// File: tb/tb_clock_gen.sv
// free running clock from time zero; reset released a quarter period after the last reset edge
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic arst_n
);

	// 50/50 duty
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// release away from the rising edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#(PERIOD_NS / 4);
		arst_n = 1'b1;
	end

endmodule

// File: tb/tb_test_frame_source.sv
// frame table run back to back; expected words come from a model of the pattern and crc rules
`timescale 1ns/1ps

module tb_test_frame_source;
	import test_frame_pkg::*;

	localparam int BLANK       = 4;
	localparam int NUM_ENTRIES = 10;
	localparam int DRIVE_DLY   = 10;

	// frame_size, pattern, extra start offset (0 none), expected words, first valid edge
	typedef struct {
		int       frame_size;
		pattern_t pat;
		int       extra_start;
		int       exp_words;
		int       exp_first;
	} entry_t;

	logic                    clk;
	logic                    arst_n;
	logic                    start;
	logic [FRAME_SIZE_W-1:0] frame_size;
	pattern_t                pattern_sel;
	logic [DATA_W-1:0]       dout;
	logic                    dout_valid;
	logic                    dout_fval;
	logic                    dout_crc_beat;
	logic                    busy;

	entry_t stim [NUM_ENTRIES];
	int     cycle_cnt = 0;
	int     cycle_limit = 0;
	int     errors = 0;
	int     frame_errors = 0;
	int     words_checked = 0;
	int     frame_num = 0;

	tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(2)) u_clk (.clk(clk), .arst_n(arst_n));

	test_frame_source #(.BLANK_CYCLES(BLANK)) DUT (
		.clk           (clk),
		.arst_n        (arst_n),
		.start         (start),
		.frame_size    (frame_size),
		.pattern_sel   (pattern_sel),
		.dout          (dout),
		.dout_valid    (dout_valid),
		.dout_fval     (dout_fval),
		.dout_crc_beat (dout_crc_beat),
		.busy          (busy)
	);

	// ----------------------------------------------------------------------
	// reference model pieces
	// ----------------------------------------------------------------------
	// msb first, one bit at a time
	function automatic logic [CRC_W-1:0] crc_fold(input logic [CRC_W-1:0] c,
		input logic [DATA_W-1:0] d);
		logic fb;
		for (int i = DATA_W - 1; i >= 0; i--) begin
			fb = c[CRC_W-1] ^ d[i];
			c  = c << 1;
			if (fb) c = c ^ CRC_POLY;
		end
		return c;
	endfunction

	// taps 32, 22, 2 and 1, new bit shifted in at the bottom
	function automatic logic [DATA_W-1:0] lfsr_advance(input logic [DATA_W-1:0] s);
		return {s[DATA_W-2:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		errors++;
		frame_errors++;
		$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
	endtask

	// ----------------------------------------------------------------------
	// one table entry, entered and left at posedge + DRIVE_DLY
	// ----------------------------------------------------------------------
	task automatic run_entry(input int e);
		logic [CRC_W-1:0]  crc_m;
		logic [DATA_W-1:0] lfsr_m;
		logic [DATA_W-1:0] exp;
		logic              exp_fval;
		int                c;
		int                seen;
		int                first;
		bit                done;
		crc_m        = CRC_INIT;
		lfsr_m       = LFSR_SEED;
		c            = 0;
		seen         = 0;
		first        = -1;
		done         = 0;
		frame_errors = 0;
		start        = 1'b1;
		frame_size   = FRAME_SIZE_W'(stim[e].frame_size);
		pattern_sel  = stim[e].pat;
		while (!done) begin
			@(posedge clk);
			#(DRIVE_DLY);
			c++;
			// frame valid spans exactly the valid words
			exp_fval = (c >= stim[e].exp_first) &&
				(c < stim[e].exp_first + stim[e].exp_words);
			if (dout_fval !== exp_fval) report_mismatch("dout_fval", dout_fval, exp_fval);
			if (dout_valid) begin
				if (first < 0) first = c;
				words_checked++;
				if (seen < stim[e].frame_size) begin
					case (stim[e].pat)
						PAT_INCR:      exp = DATA_W'(seen);
						PAT_FRAME_TAG: exp = {frame_num[7:0], 24'(seen)};
						PAT_LFSR:      exp = lfsr_m;
						default:       exp = seen[0] ? 32'hAAAA_AAAA : 32'h5555_5555;
					endcase
					if (dout !== exp) report_mismatch("dout", dout, exp);
					if (dout_crc_beat !== 1'b0) report_mismatch("dout_crc_beat", dout_crc_beat, 0);
					crc_m  = crc_fold(crc_m, exp);
					lfsr_m = lfsr_advance(lfsr_m);
				end else begin
					// trailer, the crc in both halves
					exp = {crc_m, crc_m};
					if (dout !== exp) report_mismatch("dout trailer", dout, exp);
					if (dout_crc_beat !== 1'b1) report_mismatch("dout_crc_beat", dout_crc_beat, 1);
				end
				seen++;
			end
			// drive for the next edge
			start = (c == stim[e].extra_start);
			// scramble select after sof so only the latched value counts
			if (c == 2) pattern_sel = pattern_t'(~stim[e].pat);
			if (c > 2 && !busy) done = 1;
		end
		if (seen != stim[e].exp_words) report_mismatch("valid word count", seen, stim[e].exp_words);
		if (first != stim[e].exp_first) report_mismatch("first valid edge", first, stim[e].exp_first);
		if (dout_valid !== 1'b0) report_mismatch("dout_valid after frame", dout_valid, 0);
		$display("frame %0d size %0d %s words %0d errors %0d", frame_num, stim[e].frame_size,
			stim[e].pat.name(), seen, frame_errors);
		frame_num++;
	endtask

	// ----------------------------------------------------------------------
	// timeout
	// ----------------------------------------------------------------------
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout after %0d cycles, the DUT never finished its frames", cycle_cnt);
			$display("test failed");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		start       = 1'b0;
		frame_size  = FRAME_SIZE_W'(1);
		pattern_sel = PAT_INCR;
		stim[0] = '{1, PAT_INCR, 0, 2, 2};
		stim[1] = '{5, PAT_INCR, 0, 6, 2};
		stim[2] = '{16, PAT_INCR, 0, 17, 2};
		stim[3] = '{6, PAT_FRAME_TAG, 0, 7, 2};
		stim[4] = '{6, PAT_FRAME_TAG, 0, 7, 2};
		stim[5] = '{9, PAT_LFSR, 0, 10, 2};
		// second start lands mid frame
		stim[6] = '{9, PAT_LFSR, 3, 10, 2};
		stim[7] = '{8, PAT_CHECKER, 0, 9, 2};
		// second start lands in blanking
		stim[8] = '{4, PAT_FRAME_TAG, 7, 5, 2};
		stim[9] = '{3, PAT_FRAME_TAG, 0, 4, 2};
		cycle_limit = 50;
		for (int e = 0; e < NUM_ENTRIES; e++) begin
			cycle_limit += stim[e].frame_size + 1 + BLANK + 4;
		end
		wait (arst_n === 1'b1);
		// idle outputs straight out of reset, before any edge reloads the registers
		#(DRIVE_DLY);
		if (dout_valid !== 1'b0) report_mismatch("dout_valid", dout_valid, 0);
		if (dout_fval !== 1'b0) report_mismatch("dout_fval", dout_fval, 0);
		if (dout_crc_beat !== 1'b0) report_mismatch("dout_crc_beat", dout_crc_beat, 0);
		if (busy !== 1'b0) report_mismatch("busy", busy, 0);
		$display("reset state errors %0d", errors);
		@(posedge clk);
		#(DRIVE_DLY);
		for (int e = 0; e < NUM_ENTRIES; e++) begin
			run_entry(e);
		end
		$display("frames %0d words checked %0d errors %0d assertion failures %0d",
			frame_num, words_checked, errors, DUT.u_assert.fail_count);
		if (errors == 0 && DUT.u_assert.fail_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: tb/test_frame_source_assertions.sv
// protocol checks on the top level outputs; fail_count is read by the testbench at the end
`timescale 1ns/1ps

module test_frame_source_assertions #(
	parameter int BLANK_CYCLES = 4
) (
	input logic clk,
	input logic arst_n,
	input logic fval,
	input logic dout_valid,
	input logic dout_fval,
	input logic dout_crc_beat,
	input logic busy
);

	int fail_count = 0;

	// ----------------------------------------------------------------------
	// output qualifiers
	// ----------------------------------------------------------------------
	// trailer only on a valid word
	crc_beat_valid: assert property (@(posedge clk) disable iff (!arst_n)
		dout_crc_beat |-> dout_valid)
		else begin
			fail_count++;
			$error("dout_crc_beat high without dout_valid");
		end

	valid_in_frame: assert property (@(posedge clk) disable iff (!arst_n)
		dout_valid |-> dout_fval)
		else begin
			fail_count++;
			$error("dout_valid high outside dout_fval");
		end

	// once valid drops, it stays low until the frame closes
	valid_no_gap: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(dout_valid) |-> (!dout_valid throughout (!dout_fval [->1])))
		else begin
			fail_count++;
			$error("dout_valid gap inside a frame");
		end

	// ----------------------------------------------------------------------
	// blanking
	// ----------------------------------------------------------------------
	busy_blank: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(fval) |-> busy [*BLANK_CYCLES] ##1 !busy)
		else begin
			fail_count++;
			$error("busy not held for the blanking interval");
		end

endmodule

bind test_frame_source test_frame_source_assertions #(
	.BLANK_CYCLES (BLANK_CYCLES)
) u_assert (
	.clk           (clk),
	.arst_n        (arst_n),
	.fval          (fval),
	.dout_valid    (dout_valid),
	.dout_fval     (dout_fval),
	.dout_crc_beat (dout_crc_beat),
	.busy          (busy)
);
